//--- common/dbg_pkg.sv
// Debug network widths, channel numbers and flit types
// Flit struct with its two-way decoded content word
// Bit positions of the system control word
package dbg_pkg;

   localparam int DBG_DATA_WIDTH = 16; // Also the FX2 word width
   localparam int DBG_TYPE_WIDTH = 2;

   localparam int DBG_VCHANNELS = 2;
   localparam int DBG_CONF_VCHANNEL = 0;
   localparam int DBG_TRACE_VCHANNEL = 1;

   // Flit type encoding as used on the debug network
   typedef enum logic [DBG_TYPE_WIDTH-1:0] {
      PAYLOAD = 2'b00,
      HEADER  = 2'b01,
      LAST    = 2'b10,
      SINGLE  = 2'b11  // Header without payload
   } flit_type_e;

   // Layout of the first flit of a packet
   typedef struct packed {
      logic [7:0] dest;
      logic       vc;
      logic [2:0] pkt_class; // Passed along untouched
      logic [3:0] len;       // Payload words that follow
   } dbg_header_t;

   typedef union packed {
      logic [DBG_DATA_WIDTH-1:0] raw;
      dbg_header_t               hdr;
   } dbg_content_u;

   typedef struct packed {
      flit_type_e   ftype;
      dbg_content_u content;
   } dbg_flit_t;

   // Control word bits
   localparam int CTRL_CPU_RESET = 0;
   localparam int CTRL_CPU_STALL = 1;
   localparam int CTRL_CPU_START = 2;
   localparam int CTRL_SYS_HALT = 3;

endpackage

//--- hw/usb_bridge/fx2_ep_out_reader.sv
// Endpoint-out reader for the FX2 slave FIFO
// Frames host words into typed debug flits
module fx2_ep_out_reader
   import dbg_pkg::*;
(
   input  logic                      clk,
   input  logic                      reset_i,

   input  logic [DBG_DATA_WIDTH-1:0] fx2_fd_i,
   input  logic                      fx2_ep_out_empty_i,
   output logic                      fx2_slrd_o,

   output dbg_flit_t                 flit_o,
   output logic                      flit_valid_o,
   input  logic                      flit_ready_i
);

   logic         run_q;    // Set one cycle after reset
   logic [3:0]   remain_q; // Payload words still to come
   logic         take;
   dbg_content_u word;
   flit_type_e   word_type;

   assign word = fx2_fd_i;

   // Output register is free or drains this cycle
   assign take = run_q && !fx2_ep_out_empty_i && (!flit_valid_o || flit_ready_i);
   assign fx2_slrd_o = take;

   always_comb begin
      if (remain_q == '0) begin
         // New packet starts here
         word_type = (word.hdr.len == '0) ? SINGLE : HEADER;
      end else begin
         word_type = (remain_q == 4'd1) ? LAST : PAYLOAD;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         run_q <= 1'b0;
         remain_q <= '0;
         flit_valid_o <= 1'b0;
      end else begin
         run_q <= 1'b1;
         if (take) begin
            flit_valid_o <= 1'b1;
            if (remain_q == '0) begin
               remain_q <= word.hdr.len; // Header loads the count
            end else begin
               remain_q <= remain_q - 4'd1;
            end
         end else if (flit_ready_i) begin
            flit_valid_o <= 1'b0;
         end
      end
   end

   // Flit payload register
   always_ff @(posedge clk) begin
      if (take) begin
         flit_o.ftype <= word_type;
         flit_o.content <= word;
      end
   end

endmodule

//--- hw/usb_bridge/fx2_ep_in_writer.sv
// Endpoint-in writer for the FX2 slave FIFO
// One FIFO word per flit, stalled by the full flag
module fx2_ep_in_writer
   import dbg_pkg::*;
(
   input  dbg_flit_t                 flit_i,
   input  logic                      flit_valid_i,
   output logic                      flit_ready_o,

   input  logic                      fx2_ep_in_full_i,
   output logic                      fx2_slwr_o,
   output logic [DBG_DATA_WIDTH-1:0] fx2_fd_o,
   output logic                      fx2_fd_oe_o
);

   // Host rebuilds framing from the header len
   assign fx2_fd_o = flit_i.content.raw;

   assign flit_ready_o = !fx2_ep_in_full_i;
   assign fx2_slwr_o = flit_valid_i && !fx2_ep_in_full_i; // Write on transfer only

   // Board wrapper drives the data bus only while writing
   assign fx2_fd_oe_o = fx2_slwr_o;

endmodule

//--- hw/dbg_noc/dbg_packet_router.sv
// Steers host packets to a debug virtual channel
// Absorbs system control packets and holds the control outputs
module dbg_packet_router
   import dbg_pkg::*;
#(
   parameter logic [7:0] SYSCTRL_DEST = 8'h00
) (
   input  logic                     clk,
   input  logic                     reset_i,

   input  dbg_flit_t                in_flit_i,
   input  logic                     in_valid_i,
   output logic                     in_ready_o,

   output dbg_flit_t                out_flit_o,
   output logic [DBG_VCHANNELS-1:0] out_valid_o,
   input  logic [DBG_VCHANNELS-1:0] out_ready_i,

   output logic                     cpu_reset_o,
   output logic                     cpu_stall_o,
   output logic                     cpu_start_o,
   output logic                     sys_halt_o
);

   localparam int VC_W = $clog2(DBG_VCHANNELS);

   logic            is_head;
   logic            cur_ctrl; // Packet belongs to system control
   logic            ctrl_q;
   logic [VC_W-1:0] cur_vc;
   logic [VC_W-1:0] vc_q;
   logic            xfer;

   assign is_head = (in_flit_i.ftype == HEADER) || (in_flit_i.ftype == SINGLE);

   // Header decodes, later flits follow the held choice
   always_comb begin
      if (is_head) begin
         cur_ctrl = (in_flit_i.content.hdr.dest == SYSCTRL_DEST);
         cur_vc = in_flit_i.content.hdr.vc ? VC_W'(DBG_TRACE_VCHANNEL)
                                           : VC_W'(DBG_CONF_VCHANNEL);
      end else begin
         cur_ctrl = ctrl_q;
         cur_vc = vc_q;
      end
   end

   assign out_flit_o = in_flit_i;

   always_comb begin
      out_valid_o = '0;
      if (in_valid_i && !cur_ctrl) begin
         out_valid_o[cur_vc] = 1'b1;
      end
   end

   // Control packets are always sunk
   assign in_ready_o = cur_ctrl ? 1'b1 : out_ready_i[cur_vc];
   assign xfer = in_valid_i && in_ready_o;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ctrl_q <= 1'b0;
         vc_q <= '0;
         cpu_reset_o <= 1'b0;
         cpu_stall_o <= 1'b0;
         cpu_start_o <= 1'b0;
         sys_halt_o <= 1'b0;
      end else begin
         cpu_start_o <= 1'b0; // Start is a pulse
         if (xfer && in_flit_i.ftype == HEADER) begin
            ctrl_q <= cur_ctrl;
            vc_q <= cur_vc;
         end
         if (xfer && cur_ctrl && in_flit_i.ftype == LAST) begin
            cpu_reset_o <= in_flit_i.content.raw[CTRL_CPU_RESET];
            cpu_stall_o <= in_flit_i.content.raw[CTRL_CPU_STALL];
            cpu_start_o <= in_flit_i.content.raw[CTRL_CPU_START];
            sys_halt_o <= in_flit_i.content.raw[CTRL_SYS_HALT];
         end
      end
   end

endmodule

//--- hw/dbg_noc/dbg_vc_arbiter.sv
// Round-robin arbiter over the incoming debug channels
// Grant is held for a whole packet
module dbg_vc_arbiter
   import dbg_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset_i,

   input  dbg_flit_t                in_flit_i,
   input  logic [DBG_VCHANNELS-1:0] in_valid_i,
   output logic [DBG_VCHANNELS-1:0] in_ready_o,

   output dbg_flit_t                out_flit_o,
   output logic                     out_valid_o,
   input  logic                     out_ready_i
);

   localparam int VC_W = $clog2(DBG_VCHANNELS);

   logic            lock_q;
   logic [VC_W-1:0] grant_q;
   logic [VC_W-1:0] last_q;    // Channel of the previous packet
   logic [VC_W-1:0] pick;
   logic [VC_W-1:0] cur_grant;
   logic            found;
   logic            xfer;
   logic            pkt_end;

   // Search starts just after the last granted channel
   always_comb begin
      int idx;
      pick = last_q;
      found = 1'b0;
      for (int i = 1; i <= DBG_VCHANNELS; i++) begin
         idx = (int'(last_q) + i) % DBG_VCHANNELS;
         if (!found && in_valid_i[idx]) begin
            pick = VC_W'(idx);
            found = 1'b1;
         end
      end
   end

   assign cur_grant = lock_q ? grant_q : pick;

   // Both channels share one flit bus
   assign out_flit_o = in_flit_i;
   assign out_valid_o = in_valid_i[cur_grant];

   always_comb begin
      in_ready_o = '0;
      in_ready_o[cur_grant] = out_ready_i;
   end

   assign xfer = out_valid_o && out_ready_i;
   assign pkt_end = (in_flit_i.ftype == LAST) || (in_flit_i.ftype == SINGLE);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         lock_q <= 1'b0;
         grant_q <= '0;
         last_q <= VC_W'(DBG_VCHANNELS - 1); // Channel 0 wins first
      end else if (!lock_q) begin
         if (found) begin
            grant_q <= pick;
            last_q <= pick;
            // Lock even before the first transfer so the flit stays stable
            lock_q <= !(xfer && pkt_end);
         end
      end else if (xfer && pkt_end) begin
         lock_q <= 1'b0;
      end
   end

endmodule

//--- hw/dbg_host_bridge.sv
// Debug host bridge top level
// FX2 endpoint FIFOs to the two-channel debug network
module dbg_host_bridge
   import dbg_pkg::*;
#(
   parameter logic [7:0] SYSCTRL_DEST = 8'h00
) (
   input  logic                      clk,
   input  logic                      reset_i,

   // FX2 slave FIFO
   input  logic [DBG_DATA_WIDTH-1:0] fx2_fd_i,
   input  logic                      fx2_ep_out_empty_i,
   output logic                      fx2_slrd_o,
   input  logic                      fx2_ep_in_full_i,
   output logic                      fx2_slwr_o,
   output logic [DBG_DATA_WIDTH-1:0] fx2_fd_o,
   output logic                      fx2_fd_oe_o,

   // Debug network
   output dbg_flit_t                 dbgnoc_out_flit_o,
   output logic [DBG_VCHANNELS-1:0]  dbgnoc_out_valid_o,
   input  logic [DBG_VCHANNELS-1:0]  dbgnoc_out_ready_i,
   input  dbg_flit_t                 dbgnoc_in_flit_i,
   input  logic [DBG_VCHANNELS-1:0]  dbgnoc_in_valid_i,
   output logic [DBG_VCHANNELS-1:0]  dbgnoc_in_ready_o,

   // System control
   output logic                      cpu_reset_o,
   output logic                      cpu_stall_o,
   output logic                      cpu_start_o,
   output logic                      sys_halt_o
);

   dbg_flit_t rd_flit;   // Reader to router
   logic      rd_valid;
   logic      rd_ready;
   dbg_flit_t arb_flit;  // Arbiter to writer
   logic      arb_valid;
   logic      arb_ready;

   fx2_ep_out_reader u_reader (
      .clk                (clk),
      .reset_i            (reset_i),
      .fx2_fd_i           (fx2_fd_i),
      .fx2_ep_out_empty_i (fx2_ep_out_empty_i),
      .fx2_slrd_o         (fx2_slrd_o),
      .flit_o             (rd_flit),
      .flit_valid_o       (rd_valid),
      .flit_ready_i       (rd_ready)
   );

   dbg_packet_router #(
      .SYSCTRL_DEST (SYSCTRL_DEST)
   ) u_router (
      .clk         (clk),
      .reset_i     (reset_i),
      .in_flit_i   (rd_flit),
      .in_valid_i  (rd_valid),
      .in_ready_o  (rd_ready),
      .out_flit_o  (dbgnoc_out_flit_o),
      .out_valid_o (dbgnoc_out_valid_o),
      .out_ready_i (dbgnoc_out_ready_i),
      .cpu_reset_o (cpu_reset_o),
      .cpu_stall_o (cpu_stall_o),
      .cpu_start_o (cpu_start_o),
      .sys_halt_o  (sys_halt_o)
   );

   dbg_vc_arbiter u_arbiter (
      .clk         (clk),
      .reset_i     (reset_i),
      .in_flit_i   (dbgnoc_in_flit_i),
      .in_valid_i  (dbgnoc_in_valid_i),
      .in_ready_o  (dbgnoc_in_ready_o),
      .out_flit_o  (arb_flit),
      .out_valid_o (arb_valid),
      .out_ready_i (arb_ready)
   );

   fx2_ep_in_writer u_writer (
      .flit_i           (arb_flit),
      .flit_valid_i     (arb_valid),
      .flit_ready_o     (arb_ready),
      .fx2_ep_in_full_i (fx2_ep_in_full_i),
      .fx2_slwr_o       (fx2_slwr_o),
      .fx2_fd_o         (fx2_fd_o),
      .fx2_fd_oe_o      (fx2_fd_oe_o)
   );

endmodule

//--- dv/tb_dbg_host_bridge.sv
// Testbench for the debug host bridge
// Endpoint FIFO and network models, vector file reader, checks and reporting
module tb_dbg_host_bridge;
   import dbg_pkg::*;

   localparam logic [7:0] CTRL_DEST = 8'hF0;
   localparam int TEST_TIMEOUT = 400;  // Cycles allowed per test
   localparam int SETTLE_CYCLES = 3;   // Reader plus control output latency

   logic                      clk = 1'b0;
   logic                      reset_i;
   logic [DBG_DATA_WIDTH-1:0] fx2_fd_i;
   logic                      fx2_ep_out_empty_i;
   logic                      fx2_slrd_o;
   logic                      fx2_ep_in_full_i;
   logic                      fx2_slwr_o;
   logic [DBG_DATA_WIDTH-1:0] fx2_fd_o;
   logic                      fx2_fd_oe_o;
   dbg_flit_t                 dbgnoc_out_flit_o;
   logic [DBG_VCHANNELS-1:0]  dbgnoc_out_valid_o;
   logic [DBG_VCHANNELS-1:0]  dbgnoc_out_ready_i;
   dbg_flit_t                 dbgnoc_in_flit_i;
   logic [DBG_VCHANNELS-1:0]  dbgnoc_in_valid_i;
   logic [DBG_VCHANNELS-1:0]  dbgnoc_in_ready_o;
   logic                      cpu_reset_o;
   logic                      cpu_stall_o;
   logic                      cpu_start_o;
   logic                      sys_halt_o;

   logic [15:0] host_q[$];  // Endpoint-out FIFO contents
   dbg_flit_t   net0_q[$];  // Flits offered on input channel 0
   dbg_flit_t   net1_q[$];
   dbg_flit_t   exp0_q[$];  // Expected on output channel 0
   dbg_flit_t   exp1_q[$];
   logic [15:0] ein_q[$];   // Expected endpoint-in words
   logic [3:0]  exp_ctrl;
   string       test_name;
   int          errors = 0;
   int          errors_at_start;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          start_pulses;
   int          net_ch;     // Channel offered now, -1 between packets
   int          net_last;
   logic        timed_out = 1'b0;

   always #20 clk = ~clk;

   dbg_host_bridge #(
      .SYSCTRL_DEST (CTRL_DEST)
   ) u_dut (
      .clk                (clk),
      .reset_i            (reset_i),
      .fx2_fd_i           (fx2_fd_i),
      .fx2_ep_out_empty_i (fx2_ep_out_empty_i),
      .fx2_slrd_o         (fx2_slrd_o),
      .fx2_ep_in_full_i   (fx2_ep_in_full_i),
      .fx2_slwr_o         (fx2_slwr_o),
      .fx2_fd_o           (fx2_fd_o),
      .fx2_fd_oe_o        (fx2_fd_oe_o),
      .dbgnoc_out_flit_o  (dbgnoc_out_flit_o),
      .dbgnoc_out_valid_o (dbgnoc_out_valid_o),
      .dbgnoc_out_ready_i (dbgnoc_out_ready_i),
      .dbgnoc_in_flit_i   (dbgnoc_in_flit_i),
      .dbgnoc_in_valid_i  (dbgnoc_in_valid_i),
      .dbgnoc_in_ready_o  (dbgnoc_in_ready_o),
      .cpu_reset_o        (cpu_reset_o),
      .cpu_stall_o        (cpu_stall_o),
      .cpu_start_o        (cpu_start_o),
      .sys_halt_o         (sys_halt_o)
   );

   task automatic check_value(input string what, input logic [17:0] expected,
                              input logic [17:0] actual);
      if (expected !== actual) begin
         $display("[ERROR] %s: %s expected %h, actual %h", test_name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic report_failure(input string what);
      $display("Failure in %s: %s", test_name, what);
      errors++;
   endtask

   function automatic flit_type_e type_from_letter(input string letter);
      flit_type_e t;
      if (letter == "H") t = HEADER;
      else if (letter == "L") t = LAST;
      else if (letter == "S") t = SINGLE;
      else t = PAYLOAD;
      return t;
   endfunction

   function automatic logic all_consumed();
      return host_q.size() == 0 && net0_q.size() == 0 && net1_q.size() == 0 &&
             exp0_q.size() == 0 && exp1_q.size() == 0 && ein_q.size() == 0;
   endfunction

   task automatic drive_inputs();
      fx2_ep_out_empty_i = (host_q.size() == 0);
      fx2_fd_i = (host_q.size() == 0) ? '0 : host_q[0]; // First word falls through
      fx2_ep_in_full_i = ($urandom_range(3) == 0);
      dbgnoc_out_ready_i = DBG_VCHANNELS'($urandom);
      // Upstream node picks a channel per packet, the other one first
      if (net_ch < 0) begin
         if (net_last == 1) begin
            if (net0_q.size() > 0) net_ch = 0;
            else if (net1_q.size() > 0) net_ch = 1;
         end else begin
            if (net1_q.size() > 0) net_ch = 1;
            else if (net0_q.size() > 0) net_ch = 0;
         end
      end
      dbgnoc_in_valid_i = '0;
      dbgnoc_in_flit_i = '0;
      if (net_ch == 0 && net0_q.size() > 0) begin
         dbgnoc_in_valid_i[0] = 1'b1;
         dbgnoc_in_flit_i = net0_q[0];
      end else if (net_ch == 1 && net1_q.size() > 0) begin
         dbgnoc_in_valid_i[1] = 1'b1;
         dbgnoc_in_flit_i = net1_q[0];
      end
   endtask

   task automatic sample_outputs();
      logic in_xfer;
      logic wr_exp;
      // An offered network flit goes straight out unless the FIFO is full
      wr_exp = (|dbgnoc_in_valid_i) && !fx2_ep_in_full_i;
      if (fx2_slrd_o) begin
         if (host_q.size() == 0) report_failure("endpoint-out read while the FIFO was empty");
         else host_q.delete(0);
      end
      if (dbgnoc_out_valid_o == 2'b11) report_failure("flit valid on both output channels");
      if (dbgnoc_out_valid_o[0] && dbgnoc_out_ready_i[0]) begin
         if (exp0_q.size() == 0) begin
            report_failure("unexpected flit on output channel 0");
         end else begin
            check_value("channel 0 flit", exp0_q[0], dbgnoc_out_flit_o);
            exp0_q.delete(0);
         end
      end
      if (dbgnoc_out_valid_o[1] && dbgnoc_out_ready_i[1]) begin
         if (exp1_q.size() == 0) begin
            report_failure("unexpected flit on output channel 1");
         end else begin
            check_value("channel 1 flit", exp1_q[0], dbgnoc_out_flit_o);
            exp1_q.delete(0);
         end
      end
      check_value("endpoint-in write strobe", 18'(wr_exp), 18'(fx2_slwr_o));
      check_value("data output enable", 18'(wr_exp), 18'(fx2_fd_oe_o));
      if (fx2_slwr_o) begin
         if (fx2_ep_in_full_i) begin
            report_failure("endpoint-in word written while the FIFO was full");
         end else if (ein_q.size() == 0) begin
            report_failure("unexpected endpoint-in word");
         end else begin
            check_value("endpoint-in word", 18'(ein_q[0]), 18'(fx2_fd_o));
            ein_q.delete(0);
         end
      end
      if (net_ch >= 0) begin
         check_value("ready of the idle input channel", 18'(0),
                     18'((net_ch == 0) ? dbgnoc_in_ready_o[1] : dbgnoc_in_ready_o[0]));
         in_xfer = (net_ch == 0) ? dbgnoc_in_ready_o[0] : dbgnoc_in_ready_o[1];
         check_value("ready of the offered input channel", 18'(wr_exp), 18'(in_xfer));
         if (in_xfer) begin
            if (net_ch == 0) net0_q.delete(0);
            else net1_q.delete(0);
            if (dbgnoc_in_flit_i.ftype == LAST || dbgnoc_in_flit_i.ftype == SINGLE) begin
               net_last = net_ch;
               net_ch = -1;
            end
         end
      end
      if (cpu_start_o) start_pulses++;
   endtask

   // Drive just after the rising edge, sample at the falling edge
   task automatic step();
      @(posedge clk);
      #1;
      drive_inputs();
      @(negedge clk);
      sample_outputs();
   endtask

   task automatic start_test(input string name);
      test_name = name;
      exp_ctrl = '0;
      start_pulses = 0;
      net_ch = -1;
      net_last = 1;
      errors_at_start = errors;
   endtask

   task automatic finish_test();
      tests_run++;
      if (errors == errors_at_start) begin
         $display("PASS  %s", test_name);
      end else begin
         tests_failed++;
         $display("FAIL  %s", test_name);
      end
   endtask

   task automatic run_test();
      int cycles;
      cycles = 0;
      while (!all_consumed() && cycles < TEST_TIMEOUT) begin
         step();
         cycles++;
      end
      if (!all_consumed()) begin
         report_failure("timed out before all host words, flits and expected words were seen");
         timed_out = 1'b1;
      end else begin
         repeat (SETTLE_CYCLES) step();
         check_value("cpu_reset_o", 18'(exp_ctrl[CTRL_CPU_RESET]), 18'(cpu_reset_o));
         check_value("cpu_stall_o", 18'(exp_ctrl[CTRL_CPU_STALL]), 18'(cpu_stall_o));
         check_value("sys_halt_o", 18'(exp_ctrl[CTRL_SYS_HALT]), 18'(sys_halt_o));
         check_value("cpu_start_o pulses", 18'(exp_ctrl[CTRL_CPU_START]), 18'(start_pulses));
      end
      finish_test();
   endtask

   task automatic parse_token(input string tok);
      dbg_flit_t flit;
      string     key;
      key = tok.substr(0, 0);
      if (key == "h") begin
         host_q.push_back(16'(tok.substr(1, tok.len() - 1).atohex()));
      end else if (key == "w") begin
         ein_q.push_back(16'(tok.substr(1, tok.len() - 1).atohex()));
      end else if (key == "c") begin
         exp_ctrl = 4'(tok.substr(1, tok.len() - 1).atohex());
      end else begin
         flit.ftype = type_from_letter(tok.substr(2, 2));
         flit.content.raw = 16'(tok.substr(3, tok.len() - 1).atohex());
         key = tok.substr(0, 1);
         if (key == "i0") net0_q.push_back(flit);
         else if (key == "i1") net1_q.push_back(flit);
         else if (key == "o0") exp0_q.push_back(flit);
         else if (key == "o1") exp1_q.push_back(flit);
         else report_failure($sformatf("unknown token %s in the test file", tok));
      end
   endtask

   task automatic run_file(input int fd);
      string tok;
      string rest;
      int    code;
      logic  in_test;
      in_test = 1'b0;
      code = 1;
      while (code == 1 && !timed_out) begin
         code = $fscanf(fd, "%s", tok);
         if (code == 1) begin
            if (tok.substr(0, 0) == "#") code = $fgets(rest, fd) > 0 ? 1 : 0; // Comment line
            else if (!in_test) begin
               start_test(tok);
               in_test = 1'b1;
            end else if (tok == "end") begin
               run_test();
               in_test = 1'b0;
            end else parse_token(tok);
         end
      end
   endtask

   initial begin
      int fd;
      void'($urandom(42));
      reset_i = 1'b1;
      // Endpoint-out FIFO holds a word all through reset
      fx2_fd_i = 16'h2103;
      fx2_ep_out_empty_i = 1'b0;
      fx2_ep_in_full_i = 1'b0;
      dbgnoc_out_ready_i = '1;
      dbgnoc_in_flit_i = '0;
      dbgnoc_in_valid_i = '0;
      start_test("reset_state");
      for (int i = 0; i < 3; i++) begin
         @(posedge clk);
         #1;
         if (i == 2) reset_i = 1'b0;
         @(negedge clk);
         check_value("outputs in reset", 18'(0),
                     18'({fx2_slrd_o, fx2_slwr_o, dbgnoc_out_valid_o,
                          cpu_reset_o, cpu_stall_o, cpu_start_o, sys_halt_o}));
      end
      finish_test();
      fd = $fopen("dv/bridge_tests.txt", "r");
      if (fd == 0) begin
         report_failure("cannot open dv/bridge_tests.txt");
      end else begin
         run_file(fd);
         $fclose(fd);
      end
      $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- dv/bridge_tests.txt
# One test per line: name, then tokens, closed by end
# hWORD host word, iCT WORD offered flit on input channel C, oCTWORD expected flit on output C
# T is H header, P payload, L last, S single; wWORD expected endpoint-in word
# cX expected control state, bit 0 reset, 1 stall, 2 one start pulse, 3 halt
# The bridge's own destination is F0; headers are dest, vc, class and len
frame_len3 h2103 h1111 h2222 h3333 o0H2103 o0P1111 o0P2222 o0L3333 c0 end
frame_single h2210 o0S2210 c0 end
frame_vc1 h5184 h0a0a h0b0b h0c0c h0d0d o1H5184 o1P0a0a o1P0b0b o1P0c0c o1L0d0d c0 end
steer_vc h4182 haaaa hbbbb h4201 hcccc h43a0 o1H4182 o1Paaaa o1Lbbbb o0H4201 o0Lcccc o1S43a0 c0 end
ctrl_stall_halt hF001 h000A h2201 h5555 o0H2201 o0L5555 cA end
ctrl_start hF002 h1234 h0006 c6 end
ctrl_single hF000 c2 end
ctrl_clear hF001 h0000 c0 end
ein_packet i0H0102 i0Paaaa i0Lbbbb w0102 waaaa wbbbb c0 end
ein_burst i1H3003 i1P0001 i1P0002 i1L0003 w3003 w0001 w0002 w0003 c0 end
arb_rr i0H1001 i0La001 i0S1100 i1H2001 i1Lc001 i1S2100 w1001 wa001 w2001 wc001 w1100 w2100 c0 end
mixed hF001 h0008 h4181 heeee o1H4181 o1Leeee i1S3000 i0H3101 i0Lf00f w3101 wf00f w3000 c8 end

//--- verilog.f
common/dbg_pkg.sv
hw/usb_bridge/fx2_ep_out_reader.sv
hw/usb_bridge/fx2_ep_in_writer.sv
hw/dbg_noc/dbg_packet_router.sv
hw/dbg_noc/dbg_vc_arbiter.sv
hw/dbg_host_bridge.sv
dv/tb_dbg_host_bridge.sv

//--- Makefile
TOP = tb_dbg_host_bridge

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module dbg_host_bridge

sim:
	verilator --binary --timing -j 0 -f verilog.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
